// File: compile.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_if.sv
verilog/icache_lookup_setup.sv
verilog/icache_tag_data_ram.sv
verilog/icache_hit_ctrl.sv
verilog/icache_fill_biu.sv
verilog/icache_top.sv
tb/tb_clock_gen.sv
tb/icache_tb.sv

// File: tb/icache_tb.sv
/*
  Instruction cache testbench: fetch stimulus, burst bus model,
  assertion checks and summary
*/
`include "icache_defs.svh"

module icache_tb;

  localparam logic [31:0] PATTERN = 32'h5A3C_96E1;  // Bus word = address ^ PATTERN
  localparam int          TIMEOUT = 200;

  logic                    clk, rst_n;
  logic                    mem_req = 1'b0;
  logic [`ICACHE_XLEN-1:0] mem_adr = '0;
  logic                    mem_flush = 1'b0;
  logic                    cache_flush = 1'b0;
  logic                    mem_stall, parcel_valid, parcel_error;
  logic [`ICACHE_XLEN-1:0] parcel_pc, parcel;
  logic                    biu_stb;
  logic [`ICACHE_XLEN-1:0] biu_adri;
  logic                    biu_stb_ack = 1'b0;
  logic                    biu_ack = 1'b0;
  logic                    biu_err = 1'b0;
  logic [`ICACHE_XLEN-1:0] biu_q = '0;

  int          bus_phase = 0;
  logic [31:0] bus_line = '0;
  logic [31:0] err_line = '0;
  logic        inject_err = 1'b0;
  logic        hit_expected = 1'b0;  // Presented fetch must hit
  logic [31:0] last_adr = '0;
  logic        accepted;
  int          stb_count = 0;
  int          parcel_count = 0;
  int          error_count = 0;
  int          mark = 0;
  int          tests_done = 0;
  integer      seed = 86;

  tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(5)) clock_gen_inst (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  icache_top icache_top_inst (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .mem_req_i      ( mem_req      ),
    .mem_adr_i      ( mem_adr      ),
    .mem_flush_i    ( mem_flush    ),
    .cache_flush_i  ( cache_flush  ),
    .mem_stall_o    ( mem_stall    ),
    .parcel_pc_o    ( parcel_pc    ),
    .parcel_o       ( parcel       ),
    .parcel_valid_o ( parcel_valid ),
    .parcel_error_o ( parcel_error ),
    .biu_stb_o      ( biu_stb      ),
    .biu_adri_o     ( biu_adri     ),
    .biu_stb_ack_i  ( biu_stb_ack  ),
    .biu_q_i        ( biu_q        ),
    .biu_ack_i      ( biu_ack      ),
    .biu_err_i      ( biu_err      )
  );

  assign accepted = mem_req && !mem_stall;

  // ------------------------------------------------------------------
  // Bus model, strobe ack after 2 cycles, then 4 single-cycle beats
  // ------------------------------------------------------------------
  always @(posedge clk) begin
    biu_stb_ack <= 1'b0;
    biu_ack     <= 1'b0;
    biu_err     <= 1'b0;
    case (bus_phase)
      0: if (rst_n && biu_stb) begin
        bus_line  <= biu_adri;
        stb_count <= stb_count + 1;
        bus_phase <= 1;
      end
      1: begin
        biu_stb_ack <= 1'b1;
        bus_phase   <= 2;
      end
      default: begin  // Phase 2 carries word 0
        biu_ack <= 1'b1;
        biu_q   <= (bus_line + 32'(4 * (bus_phase - 2))) ^ PATTERN;
        if (inject_err && bus_line == err_line && bus_phase == 3) begin
          biu_err   <= 1'b1;  // Second beat fails
          bus_phase <= 0;
        end else begin
          bus_phase <= (bus_phase == 5) ? 0 : bus_phase + 1;
        end
      end
    endcase
  end

  always @(posedge clk) begin
    if (rst_n && accepted) last_adr <= mem_adr;
  end

  // Counted between edges so the count is settled at each rising edge
  always @(negedge clk) begin
    if (rst_n && parcel_valid) parcel_count <= parcel_count + 1;
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  assert property (@(posedge clk) disable iff (!rst_n)
    parcel_valid && !parcel_error |-> parcel == (parcel_pc ^ PATTERN))
    else note_mismatch("parcel_o", $sampled(parcel), $sampled(parcel_pc) ^ PATTERN);

  assert property (@(posedge clk) disable iff (!rst_n)
    accepted && hit_expected |-> ##2 (parcel_valid && parcel_pc == $past(mem_adr, 2)))
    else note_failure("hit parcel missing two cycles after acceptance");

  assert property (@(posedge clk) disable iff (!rst_n)
    hit_expected |-> !mem_stall && !biu_stb)
    else note_failure("fetch expected to hit was stalled or went to the bus");

  // Strobe carries the line of the fetch that missed
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(biu_stb) |-> biu_adri == {last_adr[31:4], 4'h0})
    else note_mismatch("biu_adri_o", $sampled(biu_adri), {$sampled(last_adr[31:4]), 4'h0});

  assert property (@(posedge clk) disable iff (!rst_n)
    accepted ##1 mem_flush |=> !parcel_valid)
    else note_failure("parcel delivered for a flushed fetch");

  assert property (@(posedge clk) disable iff (!rst_n)
    parcel_valid && $past(mem_stall) |-> !mem_stall)
    else note_failure("mem_stall_o still high with the parcel that ends a miss");

  task automatic note_mismatch(input string name, input logic [31:0] got, exp);
    error_count++;
    $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
  endtask

  task automatic note_failure(input string what);
    error_count++;
    $display("failure at %0t: %s", $time, what);
  endtask

  task automatic expect_word(input string name, input logic [31:0] got, exp);
    assert (got === exp) else note_mismatch(name, got, exp);
  endtask

  task automatic give_up(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Finished with errors");
    $finish;
  endtask

  task automatic close_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, error_count - mark);
    mark = error_count;
    tests_done++;
  endtask

  // ------------------------------------------------------------------
  // Stimulus helpers, all called just after a rising edge
  // ------------------------------------------------------------------
  task automatic present_fetch(input logic [31:0] adr, input logic hit);
    int n;
    mem_req      <= 1'b1;
    mem_adr      <= adr;
    hit_expected <= hit;
    for (n = 0; n < TIMEOUT; n++) begin
      @(posedge clk);
      if (!mem_stall) return;  // Taken at this edge
    end
    give_up("fetch request never accepted");
  endtask

  task automatic stop_fetch();
    mem_req      <= 1'b0;
    hit_expected <= 1'b0;
  endtask

  task automatic wait_parcel(output logic [31:0] pc, output logic err);
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(posedge clk);
      if (parcel_valid) begin
        pc  = parcel_pc;
        err = parcel_error;
        return;
      end
    end
    give_up("no parcel returned for a fetch");
  endtask

  task automatic wait_parcels(input int target);
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(posedge clk);
      if (parcel_count >= target) return;
    end
    give_up("fewer parcels than back-to-back fetches");
  endtask

  task automatic wait_stall_low(output int cycles);
    int n;
    cycles = 0;
    for (n = 0; n < TIMEOUT; n++) begin
      @(posedge clk);
      if (!mem_stall) return;
      cycles++;
    end
    give_up("mem_stall_o stuck high after cache flush");
  endtask

  initial begin : stimulus
    logic [31:0] base, rnd, pc, bad;
    logic [31:0] words [4];
    logic [31:0] rep [3];
    logic [8:0]  set_part;
    logic        err;
    int          stb_before, cnt_before, stall_cycles, n;

    for (n = 0; n < 20 && !rst_n; n++) @(posedge clk);
    if (!rst_n) give_up("reset never released");

    base = $random(seed) & 32'hFFFF_FFF0;
    rnd  = $random(seed);
    for (n = 0; n < 4; n++) begin
      words[n] = base + {28'h0, 2'(rnd[1:0] + n), 2'b00};  // Random first word
    end

    // Test 1, cold miss
    stb_before = stb_count;
    present_fetch(words[0], 1'b0);
    stop_fetch();
    wait_parcel(pc, err);
    expect_word("parcel_pc_o", pc, words[0]);
    expect_word("strobe count", stb_count - stb_before, 1);
    close_test(1, "cold miss");

    // Test 2, hits, single and back to back
    stb_before = stb_count;
    present_fetch(words[1], 1'b1);
    stop_fetch();
    wait_parcel(pc, err);
    expect_word("parcel_pc_o", pc, words[1]);
    cnt_before = parcel_count;
    present_fetch(words[2], 1'b1);
    present_fetch(words[3], 1'b1);
    present_fetch(words[0], 1'b1);
    stop_fetch();
    wait_parcels(cnt_before + 3);
    expect_word("strobe count", stb_count - stb_before, 0);
    close_test(2, "hit");

    // Test 3, flush one cycle after acceptance
    present_fetch(words[1], 1'b0);
    stop_fetch();
    mem_flush <= 1'b1;
    @(posedge clk);
    mem_flush <= 1'b0;
    present_fetch(words[2], 1'b1);
    stop_fetch();
    wait_parcel(pc, err);
    expect_word("parcel_pc_o", pc, words[2]);
    close_test(3, "pipeline flush");

    // Test 4, three tags in one set
    set_part = 9'($random(seed)) & 9'h1FC;
    for (n = 0; n < 3; n++) begin
      rnd    = $random(seed);
      rep[n] = {rnd[31:11], n[1:0], set_part};  // Distinct tags
      present_fetch(rep[n], 1'b0);
      stop_fetch();
      wait_parcel(pc, err);
      expect_word("parcel_pc_o", pc, rep[n]);
    end
    stb_before = stb_count;
    for (n = 0; n < 3; n++) begin
      present_fetch(rep[n], 1'b0);
      stop_fetch();
      wait_parcel(pc, err);
      expect_word("parcel_pc_o", pc, rep[n]);
    end
    assert (stb_count > stb_before)
      else note_failure("three lines of one set stayed resident in two ways");
    close_test(4, "replacement");

    // Test 5, invalidation of a line that hits
    present_fetch(words[0], 1'b0);     // Test 4 may have evicted it
    stop_fetch();
    wait_parcel(pc, err);
    present_fetch(words[0], 1'b1);
    stop_fetch();
    wait_parcel(pc, err);
    cache_flush <= 1'b1;
    @(posedge clk);
    cache_flush <= 1'b0;
    wait_stall_low(stall_cycles);
    assert (stall_cycles >= 32)
      else note_failure("cache flush stall shorter than one cycle per set");
    stb_before = stb_count;
    present_fetch(words[0], 1'b0);
    stop_fetch();
    wait_parcel(pc, err);
    expect_word("strobe count", stb_count - stb_before, 1);
    close_test(5, "invalidation");

    // Test 6, bus error on the second beat
    rnd = $random(seed);
    bad = {rnd[31:2], 2'b00};
    if (bad[31:4] == words[0][31:4]) bad[31] = ~bad[31];
    err_line   <= {bad[31:4], 4'h0};
    inject_err <= 1'b1;
    present_fetch(bad, 1'b0);
    stop_fetch();
    wait_parcel(pc, err);
    expect_word("parcel_error_o", err, 1);
    inject_err <= 1'b0;
    stb_before = stb_count;
    present_fetch(bad, 1'b0);
    stop_fetch();
    wait_parcel(pc, err);
    expect_word("parcel_error_o", err, 0);
    expect_word("strobe count", stb_count - stb_before, 1);
    close_test(6, "bus error");

    $display("tests run %0d, errors %0d", tests_done, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: tb/tb_clock_gen.sv
/*
  Testbench clock and active low reset
*/
module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;                          // Asserted from time zero
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: verilog/icache_defs.svh
/*
  Instruction cache configuration macros
*/
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Word and address width
`define ICACHE_XLEN       32

// Words per line, also beats per fill
`define ICACHE_LINE_WORDS 4

// Geometry
`define ICACHE_SETS       32
`define ICACHE_WAYS       2

// Random replacement
`define ICACHE_LFSR_BITS  7

`endif

// File: verilog/icache_fill_biu.sv
/*
  Bus fill controller: strobe handshake, 4-beat burst into a line buffer
*/
`include "icache_defs.svh"

module icache_fill_biu (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  icache_fill_if.responder        fill,

  output logic                    biu_stb_o,
  output logic [`ICACHE_XLEN-1:0] biu_adri_o,
  input  logic                    biu_stb_ack_i,
  input  logic [`ICACHE_XLEN-1:0] biu_q_i,
  input  logic                    biu_ack_i,
  input  logic                    biu_err_i
);
  import icache_pkg::*;

  fill_state_e          state;
  logic [OFFS_BITS-1:0] beat_cnt;
  logic [LINE_BITS-1:0] line_buf;

  assign biu_stb_o  = (state == FILL_REQ);
  assign biu_adri_o = fill.line_adr.flat;  // Already line aligned
  assign fill.line  = line_buf;

  //--------------------------------------------------------------------
  // Burst FSM
  //--------------------------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state          <= FILL_IDLE;
      beat_cnt       <= '0;
      fill.fill_done <= 1'b0;
      fill.fill_err  <= 1'b0;
    end else begin
      fill.fill_done <= 1'b0;

      case (state)
        FILL_IDLE: begin
          // Request is still high in the done cycle
          if (fill.fill_req && !fill.fill_done) state <= FILL_REQ;
        end

        FILL_REQ: begin
          if (biu_stb_ack_i) begin
            state    <= FILL_BURST;
            beat_cnt <= '0;
          end
        end

        FILL_BURST: begin
          if (biu_err_i) begin        // Stop at the first error
            state          <= FILL_IDLE;
            fill.fill_done <= 1'b1;
            fill.fill_err  <= 1'b1;
          end else if (biu_ack_i) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == OFFS_BITS'(`ICACHE_LINE_WORDS - 1)) begin
              state          <= FILL_IDLE;
              fill.fill_done <= 1'b1;
              fill.fill_err  <= 1'b0;
            end
          end
        end

        default: state <= FILL_IDLE;
      endcase
    end
  end

  // Beats land in order, word 0 first
  always_ff @(posedge clk_i) begin
    if (state == FILL_BURST && biu_ack_i && !biu_err_i) begin
      line_buf[beat_cnt*`ICACHE_XLEN +: `ICACHE_XLEN] <= biu_q_i;
    end
  end

  // Strobe and its address held until acknowledged
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_stb_o && !biu_stb_ack_i |=> biu_stb_o && $stable(biu_adri_o))
    else $error("biu_stb_o or biu_adri_o changed before biu_stb_ack_i");

endmodule

// File: verilog/icache_hit_ctrl.sv
/*
  Hit stage: parcel output, miss handling, stall, random way LFSR
*/
`include "icache_defs.svh"

module icache_hit_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  icache_lookup_if.hit                     lookup,
  input  logic                             hit_i,
  input  logic [icache_pkg::LINE_BITS-1:0] line_i,
  input  logic                             flushing_i,

  icache_fill_if.requester                 fill,
  output logic [`ICACHE_WAYS-1:0]          fill_way_o,

  output logic                             mem_stall_o,
  output logic [`ICACHE_XLEN-1:0]          parcel_pc_o,
  output logic [`ICACHE_XLEN-1:0]          parcel_o,
  output logic                             parcel_valid_o,
  output logic                             parcel_error_o
);
  import icache_pkg::*;

  localparam int LSB = OFFS_BITS + BYTE_BITS;  // Line offset bits

  logic                         hit_live, miss_live;
  logic                         fill_active;
  logic                         fill_killed;   // Flushed while filling
  fetch_adr_u                   miss_adr;
  logic [`ICACHE_LFSR_BITS-1:0] lfsr;

  assign hit_live  = lookup.req & hit_i & ~lookup.kill;
  assign miss_live = lookup.req & ~hit_i & ~lookup.kill;

  assign mem_stall_o   = miss_live | fill_active | flushing_i;
  assign fill.fill_req = fill_active;
  assign fill.line_adr = {miss_adr.flat[`ICACHE_XLEN-1:LSB], {LSB{1'b0}}};

  // Way from the low LFSR bits, frozen during a fill
  assign fill_way_o = `ICACHE_WAYS'(1) << lfsr[$clog2(`ICACHE_WAYS)-1:0];

  //--------------------------------------------------------------------
  // Control
  //--------------------------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      fill_active    <= 1'b0;
      fill_killed    <= 1'b0;
      parcel_valid_o <= 1'b0;
      parcel_error_o <= 1'b0;
      lfsr           <= '0;
    end else begin
      parcel_valid_o <= 1'b0;
      parcel_error_o <= 1'b0;

      if (fill_active) begin
        if (lookup.kill) fill_killed <= 1'b1;
        if (fill.fill_done) begin
          fill_active    <= 1'b0;
          parcel_valid_o <= ~fill_killed & ~lookup.kill;
          parcel_error_o <= fill.fill_err & ~fill_killed & ~lookup.kill;
        end
      end else if (miss_live) begin
        fill_active <= 1'b1;
        fill_killed <= 1'b0;
      end else if (hit_live) begin
        parcel_valid_o <= 1'b1;
      end

      if (!fill_active) begin   // XNOR feedback, all-zero start is legal
        lfsr <= {lfsr[`ICACHE_LFSR_BITS-2:0],
                 lfsr[`ICACHE_LFSR_BITS-1] ~^ lfsr[`ICACHE_LFSR_BITS-2]};
      end
    end
  end

  //--------------------------------------------------------------------
  // Parcel payload
  //--------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (fill_active && fill.fill_done) begin
      parcel_o    <= fill.line[miss_adr.f.offs*`ICACHE_XLEN +: `ICACHE_XLEN];
      parcel_pc_o <= miss_adr.flat;
    end else if (hit_live) begin
      parcel_o    <= line_i[lookup.adr.f.offs*`ICACHE_XLEN +: `ICACHE_XLEN];
      parcel_pc_o <= lookup.adr.flat;
    end

    if (miss_live) miss_adr <= lookup.adr;  // Kept for the whole fill
  end

  // Request and its line address held until the fill controller answers
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill.fill_req && !fill.fill_done |=> fill.fill_req && $stable(fill.line_adr))
    else $error("fill_req dropped or line address changed before fill_done");

  // No parcel during the invalidation walk
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    flushing_i && $past(flushing_i) && $past(flushing_i, 2) && !$past(fill.fill_done)
      |-> !parcel_valid_o)
    else $error("parcel during invalidation walk");

endmodule

// File: verilog/icache_if.sv
/*
  Lookup interface from request setup to store and hit stage,
  fill interface between hit stage and bus fill controller
*/
`include "icache_defs.svh"

interface icache_lookup_if;
  import icache_pkg::*;

  logic                req;   // One cycle per accepted fetch
  fetch_adr_u          adr;   // Registered fetch address
  logic [IDX_BITS-1:0] idx;   // Read index, valid in acceptance cycle
  logic                kill;  // Pipeline flush

  modport setup (
    output req, adr, idx, kill
  );

  modport store (
    input req, adr, idx
  );

  modport hit (
    input req, adr, kill
  );
endinterface


interface icache_fill_if;
  import icache_pkg::*;

  logic                 fill_req;
  fetch_adr_u           line_adr;   // Line aligned
  logic                 fill_done;  // Single cycle, ends the request
  logic                 fill_err;
  logic [LINE_BITS-1:0] line;

  modport requester (
    output fill_req, line_adr,
    input  fill_done, fill_err, line
  );

  modport responder (
    input  fill_req, line_adr,
    output fill_done, fill_err, line
  );

  // Store side, writes the line on a clean fill_done
  modport monitor (
    input fill_req, line_adr, fill_done, fill_err, line
  );
endinterface

// File: verilog/icache_lookup_setup.sv
/*
  Request setup stage: accepts CPU fetches, drives the store read index
*/
module icache_lookup_setup (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   mem_req_i,
  input  icache_pkg::fetch_adr_u mem_adr_i,
  input  logic                   mem_flush_i,
  input  logic                   stall_i,

  icache_lookup_if.setup         lookup
);

  logic accept;

  // A request is taken when not stalled
  assign accept = mem_req_i & ~stall_i;

  // Store read starts in the acceptance cycle
  assign lookup.idx  = mem_adr_i.f.idx;

  // Flush reaches everything already past this stage
  assign lookup.kill = mem_flush_i;

  //--------------------------------------------------------------------
  // Request flag
  //--------------------------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      lookup.req <= 1'b0;
    end else begin
      lookup.req <= accept & ~mem_flush_i;  // Concurrent flush drops it
    end
  end

  // Address travels with the request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      lookup.adr <= mem_adr_i;
    end
  end

endmodule

// File: verilog/icache_pkg.sv
/*
  Instruction cache types: fetch address union, fill FSM states,
  derived field widths
*/
`include "icache_defs.svh"

package icache_pkg;

  //--------------------------------------------------------------------
  // Address field widths
  //--------------------------------------------------------------------
  localparam int BYTE_BITS = $clog2(`ICACHE_XLEN / 8);
  localparam int OFFS_BITS = $clog2(`ICACHE_LINE_WORDS);
  localparam int IDX_BITS  = $clog2(`ICACHE_SETS);
  localparam int TAG_BITS  = `ICACHE_XLEN - IDX_BITS - OFFS_BITS - BYTE_BITS;
  localparam int LINE_BITS = `ICACHE_XLEN * `ICACHE_LINE_WORDS;  // Bits per line

  //--------------------------------------------------------------------
  // Fetch address, flat or split for lookup
  //--------------------------------------------------------------------
  typedef struct packed {
    logic [TAG_BITS-1:0]  tag;
    logic [IDX_BITS-1:0]  idx;
    logic [OFFS_BITS-1:0] offs;       // Word within line
    logic [BYTE_BITS-1:0] byte_offs;
  } fetch_fields_t;

  typedef union packed {
    logic [`ICACHE_XLEN-1:0] flat;   // Bus address and parcel pc
    fetch_fields_t           f;
  } fetch_adr_u;

  // Bus fill FSM
  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_REQ,     // Strobe held until acknowledged
    FILL_BURST    // Collecting beats
  } fill_state_e;

endpackage

// File: verilog/icache_tag_data_ram.sv
/*
  Tag, valid and data arrays per way, tag compare, line write on fill,
  invalidation walk
*/
`include "icache_defs.svh"

module icache_tag_data_ram (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  icache_lookup_if.store                   lookup,
  icache_fill_if.monitor                   fill,
  input  logic [`ICACHE_WAYS-1:0]          fill_way_i,   // One-hot

  input  logic                             cache_flush_i,
  output logic                             hit_o,
  output logic [icache_pkg::LINE_BITS-1:0] line_o,
  output logic                             flushing_o
);
  import icache_pkg::*;

  logic [`ICACHE_WAYS-1:0] way_hit;
  logic [LINE_BITS-1:0]    way_line [`ICACHE_WAYS];
  logic                    line_wr;

  logic                    flush_pend;
  logic                    walking;
  logic [IDX_BITS-1:0]     walk_idx;

  assign line_wr = fill.fill_done & ~fill.fill_err;  // Errored lines are dropped

  //--------------------------------------------------------------------
  // Per way storage
  //--------------------------------------------------------------------
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    logic [TAG_BITS-1:0]     tag_mem  [`ICACHE_SETS];
    logic [LINE_BITS-1:0]    data_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid;
    logic [TAG_BITS-1:0]     tag_rd;
    logic [LINE_BITS-1:0]    data_rd;
    logic                    valid_rd;
    logic                    way_wr;

    assign way_wr = line_wr & fill_way_i[w];

    always_ff @(posedge clk_i) begin
      if (way_wr) begin
        tag_mem[fill.line_adr.f.idx]  <= fill.line_adr.f.tag;
        data_mem[fill.line_adr.f.idx] <= fill.line;
      end
      tag_rd  <= tag_mem[lookup.idx];   // Synchronous read
      data_rd <= data_mem[lookup.idx];
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
        valid    <= '0;
        valid_rd <= 1'b0;
      end else begin
        if (walking) begin
          valid[walk_idx] <= 1'b0;
        end else if (way_wr) begin
          valid[fill.line_adr.f.idx] <= 1'b1;
        end
        valid_rd <= valid[lookup.idx];
      end
    end

    assign way_hit[w]  = valid_rd & (tag_rd == lookup.adr.f.tag);
    assign way_line[w] = way_hit[w] ? data_rd : '0;
  end

  assign hit_o = lookup.req & (|way_hit);

  // At most one way contributes
  always_comb begin
    line_o = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      line_o = line_o | way_line[w];
    end
  end

  //--------------------------------------------------------------------
  // Invalidation walk, one set per cycle
  //--------------------------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      flush_pend <= 1'b0;
      walking    <= 1'b0;
      walk_idx   <= '0;
    end else begin
      if (cache_flush_i) begin
        flush_pend <= 1'b1;
      end
      // Wait until no fetch or fill is in flight
      if (flush_pend && !walking && !fill.fill_req && !lookup.req) begin
        flush_pend <= cache_flush_i;
        walking    <= 1'b1;
        walk_idx   <= '0;
      end else if (walking) begin
        walk_idx <= walk_idx + 1'b1;
        if (walk_idx == IDX_BITS'(`ICACHE_SETS - 1)) begin
          walking <= 1'b0;
        end
      end
    end
  end

  assign flushing_o = cache_flush_i | flush_pend | walking;

  // A fill never places a tag in two ways
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lookup.req |-> $onehot0(way_hit))
    else $error("multiple ways hit");

endmodule

// File: verilog/icache_top.sv
/*
  Instruction cache top level
*/
`include "icache_defs.svh"

module icache_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // CPU side
  input  logic                    mem_req_i,
  input  logic [`ICACHE_XLEN-1:0] mem_adr_i,
  input  logic                    mem_flush_i,
  input  logic                    cache_flush_i,
  output logic                    mem_stall_o,
  output logic [`ICACHE_XLEN-1:0] parcel_pc_o,
  output logic [`ICACHE_XLEN-1:0] parcel_o,
  output logic                    parcel_valid_o,
  output logic                    parcel_error_o,

  // Bus side
  output logic                    biu_stb_o,
  output logic [`ICACHE_XLEN-1:0] biu_adri_o,
  input  logic                    biu_stb_ack_i,
  input  logic [`ICACHE_XLEN-1:0] biu_q_i,
  input  logic                    biu_ack_i,
  input  logic                    biu_err_i
);

  logic [`ICACHE_WAYS-1:0]           fill_way;
  logic                              cache_hit;
  logic [icache_pkg::LINE_BITS-1:0]  cache_line;
  logic                              flushing;

  icache_lookup_if lookup_if ();
  icache_fill_if   fill_if ();

  icache_lookup_setup lookup_setup_inst (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .mem_req_i   ( mem_req_i   ),
    .mem_adr_i   ( mem_adr_i   ),
    .mem_flush_i ( mem_flush_i ),
    .stall_i     ( mem_stall_o ),
    .lookup      ( lookup_if   )
  );

  icache_tag_data_ram tag_data_ram_inst (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .lookup        ( lookup_if     ),
    .fill          ( fill_if       ),
    .fill_way_i    ( fill_way      ),
    .cache_flush_i ( cache_flush_i ),
    .hit_o         ( cache_hit     ),
    .line_o        ( cache_line    ),
    .flushing_o    ( flushing      )
  );

  icache_hit_ctrl hit_ctrl_inst (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .lookup         ( lookup_if      ),
    .hit_i          ( cache_hit      ),
    .line_i         ( cache_line     ),
    .flushing_i     ( flushing       ),
    .fill           ( fill_if        ),
    .fill_way_o     ( fill_way       ),
    .mem_stall_o    ( mem_stall_o    ),
    .parcel_pc_o    ( parcel_pc_o    ),
    .parcel_o       ( parcel_o       ),
    .parcel_valid_o ( parcel_valid_o ),
    .parcel_error_o ( parcel_error_o )
  );

  icache_fill_biu fill_biu_inst (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .fill          ( fill_if       ),
    .biu_stb_o     ( biu_stb_o     ),
    .biu_adri_o    ( biu_adri_o    ),
    .biu_stb_ack_i ( biu_stb_ack_i ),
    .biu_q_i       ( biu_q_i       ),
    .biu_ack_i     ( biu_ack_i     ),
    .biu_err_i     ( biu_err_i     )
  );

endmodule
